/* hw/bus_cond_detect.sv */
// Bus condition detector
`timescale 1ns/1ps

module bus_cond_detect #(
  parameter int unsigned SyncStages = 2
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      scl_i,
  input  logic                      sda_i,
  output i3c_standby_pkg::bus_evt_t bus_evt_o
);
  import i3c_standby_pkg::*;

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic                  scl_prev_q;
  logic                  sda_prev_q;
  logic                  scl_s;
  logic                  sda_s;
  logic                  scl_high;
  logic                  busy_q;
  bus_evt_t              evt_d;
  bus_evt_t              bus_evt_q;

  assign scl_s = scl_sync_q[SyncStages-1];
  assign sda_s = sda_sync_q[SyncStages-1];

  // SCL must be high on both samples around the SDA edge
  assign scl_high = scl_s & scl_prev_q;

  always_comb begin
    evt_d.start    = sda_prev_q & ~sda_s & scl_high & ~busy_q;
    evt_d.rstart   = sda_prev_q & ~sda_s & scl_high & busy_q;
    evt_d.stop     = ~sda_prev_q & sda_s & scl_high;
    evt_d.scl_rise = ~scl_prev_q & scl_s;
    evt_d.scl_fall = scl_prev_q & ~scl_s;
    evt_d.sda      = sda_s;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // Idle bus reads high on both lines
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      busy_q     <= 1'b0;
      bus_evt_q  <= '0;
      bus_evt_q.sda <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;
      if (evt_d.start) begin
        busy_q <= 1'b1;
      end else if (evt_d.stop) begin
        busy_q <= 1'b0;
      end
      bus_evt_q <= evt_d;
    end
  end

  assign bus_evt_o = bus_evt_q;

  cond_onehot_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({bus_evt_o.start, bus_evt_o.rstart, bus_evt_o.stop}));

endmodule

/* hw/controller_standby.sv */
// Target standby receive top
`timescale 1ns/1ps

module controller_standby #(
  parameter int unsigned SyncStages = 2
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  // I2C/I3C bus lines
  input  logic                      scl_i,
  input  logic                      sda_i,
  output logic                      sda_o,

  // Configuration
  input  logic                      i3c_mode_i,
  input  i3c_standby_pkg::addr7_t   static_addr_i,

  // RX data queue
  output logic                      rx_queue_wvalid_o,
  input  logic                      rx_queue_wready_i,
  output i3c_standby_pkg::data_t    rx_queue_wdata_o,

  // RX descriptor queue
  output logic                      rx_desc_wvalid_o,
  input  logic                      rx_desc_wready_i,
  output i3c_standby_pkg::rx_desc_t rx_desc_wdata_o,

  // Received address with RnW bit
  output logic [7:0]                bus_addr_o,
  output logic                      bus_addr_valid_o
);
  import i3c_standby_pkg::*;

  bus_evt_t   bus_evt;
  frame_evt_t frame_evt;

  bus_cond_detect #(
    .SyncStages(SyncStages)
  ) xbus_cond_detect (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .scl_i    (scl_i),
    .sda_i    (sda_i),
    .bus_evt_o(bus_evt)
  );

  frame_receiver xframe_receiver (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .bus_evt_i        (bus_evt),
    .i3c_mode_i       (i3c_mode_i),
    .static_addr_i    (static_addr_i),
    .rx_queue_wready_i(rx_queue_wready_i),
    .sda_o            (sda_o),
    .rx_queue_wvalid_o(rx_queue_wvalid_o),
    .rx_queue_wdata_o (rx_queue_wdata_o),
    .bus_addr_o       (bus_addr_o),
    .bus_addr_valid_o (bus_addr_valid_o),
    .frame_evt_o      (frame_evt)
  );

  rx_desc_builder xrx_desc_builder (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .bus_evt_i       (bus_evt),
    .frame_evt_i     (frame_evt),
    .i3c_mode_i      (i3c_mode_i),
    .rx_desc_wready_i(rx_desc_wready_i),
    .rx_desc_wvalid_o(rx_desc_wvalid_o),
    .rx_desc_wdata_o (rx_desc_wdata_o)
  );

endmodule

/* hw/frame_receiver.sv */
// Frame receiver
`timescale 1ns/1ps

module frame_receiver (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  i3c_standby_pkg::bus_evt_t   bus_evt_i,
  input  logic                        i3c_mode_i,
  input  i3c_standby_pkg::addr7_t     static_addr_i,
  input  logic                        rx_queue_wready_i,
  output logic                        sda_o,
  output logic                        rx_queue_wvalid_o,
  output i3c_standby_pkg::data_t      rx_queue_wdata_o,
  output logic [7:0]                  bus_addr_o,
  output logic                        bus_addr_valid_o,
  output i3c_standby_pkg::frame_evt_t frame_evt_o
);
  import i3c_standby_pkg::*;

  frame_state_e state_q;
  logic [3:0]   bit_cnt_q;
  data_t        shift_q;
  data_t        byte_d;
  logic [7:0]   bus_addr_q;
  logic         addr_valid_q;
  logic         sda_drive_q;
  logic         rx_wvalid_q;
  data_t        rx_wdata_q;
  logic         rx_pending;
  logic         addr_done;
  logic         byte_complete;
  logic         hit_q;
  logic         done_q;
  logic         drop_q;
  logic         perr_q;

  assign byte_d        = {shift_q[6:0], bus_evt_i.sda};
  assign addr_done     = (state_q == ADDR) & bus_evt_i.scl_rise & (bit_cnt_q == 4'd7);
  assign byte_complete = (state_q == DATA) & bus_evt_i.scl_rise & (bit_cnt_q == 4'd7);
  assign rx_pending    = rx_wvalid_q & ~rx_queue_wready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= IDLE;
      bit_cnt_q    <= '0;
      sda_drive_q  <= 1'b0;
      addr_valid_q <= 1'b0;
      hit_q        <= 1'b0;
      perr_q       <= 1'b0;
    end else begin
      addr_valid_q <= addr_done;
      hit_q        <= 1'b0;
      perr_q       <= 1'b0;
      if (bus_evt_i.start || bus_evt_i.rstart) begin
        state_q     <= ADDR;
        bit_cnt_q   <= '0;
        sda_drive_q <= 1'b0;
      end else if (bus_evt_i.stop) begin
        state_q     <= IDLE;
        sda_drive_q <= 1'b0;
      end else begin
        case (state_q)
          ADDR, DATA: begin
            if (bus_evt_i.scl_rise) begin
              if (bit_cnt_q == 4'd7) begin
                bit_cnt_q <= 4'd8;
                if (state_q == DATA) begin
                  state_q <= BIT9;
                end else if (byte_d[7:1] == static_addr_i && !byte_d[0]) begin
                  hit_q   <= 1'b1;
                  state_q <= ADDR_ACK;
                end else begin
                  // Read or foreign address, wait for the next condition
                  state_q <= IGNORE;
                end
              end else begin
                bit_cnt_q <= bit_cnt_q + 4'd1;
              end
            end
          end
          ADDR_ACK, BIT9: begin
            if (bus_evt_i.scl_rise) begin
              bit_cnt_q <= 4'd9;
              // T-bit gives odd parity over data and itself
              if (state_q == BIT9 && i3c_mode_i && !(^{shift_q, bus_evt_i.sda})) begin
                perr_q <= 1'b1;
              end
            end else if (bus_evt_i.scl_fall) begin
              if (bit_cnt_q == 4'd8) begin
                sda_drive_q <= (state_q == ADDR_ACK) || !i3c_mode_i;
              end else begin
                sda_drive_q <= 1'b0;
                state_q     <= DATA;
                bit_cnt_q   <= '0;
              end
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  // RX data queue write port
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_wvalid_q <= 1'b0;
      done_q      <= 1'b0;
      drop_q      <= 1'b0;
    end else begin
      done_q <= byte_complete & ~rx_pending;
      drop_q <= byte_complete & rx_pending;
      if (byte_complete && !rx_pending) begin
        rx_wvalid_q <= 1'b1;
      end else if (rx_queue_wready_i) begin
        rx_wvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_evt_i.scl_rise && (state_q == ADDR || state_q == DATA)) begin
      shift_q <= byte_d;
    end
    if (addr_done) begin
      bus_addr_q <= byte_d;
    end
    if (byte_complete && !rx_pending) begin
      rx_wdata_q <= byte_d;
    end
  end

  always_comb begin
    frame_evt_o.addr_hit   = hit_q;
    frame_evt_o.addr       = bus_addr_q[7:1];
    frame_evt_o.rnw        = bus_addr_q[0];
    frame_evt_o.byte_done  = done_q;
    frame_evt_o.byte_drop  = drop_q;
    frame_evt_o.parity_err = perr_q;
  end

  // Open drain, low only while acknowledging
  assign sda_o             = ~sda_drive_q;
  assign rx_queue_wvalid_o = rx_wvalid_q;
  assign rx_queue_wdata_o  = rx_wdata_q;
  assign bus_addr_o        = bus_addr_q;
  assign bus_addr_valid_o  = addr_valid_q;

  sda_ack_only_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !sda_o |-> (state_q == ADDR_ACK) || (state_q == BIT9 && !i3c_mode_i));

endmodule

/* hw/i3c_standby_pkg.sv */
// I3C standby receive types
package i3c_standby_pkg;

  typedef logic [6:0] addr7_t;
  typedef logic [7:0] data_t;
  typedef logic [15:0] byte_cnt_t;

  // Single-cycle bus events from the condition detector
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } bus_evt_t;

  // Frame progress reported to the descriptor builder
  typedef struct packed {
    logic   addr_hit;
    addr7_t addr;
    logic   rnw;
    logic   byte_done;
    logic   byte_drop;
    logic   parity_err;
  } frame_evt_t;

  // RX descriptor word, byte count in the low half
  typedef struct packed {
    logic       parity_err;
    logic       overflow;
    logic       i3c_mode;
    logic       rnw;
    addr7_t     addr;
    logic [4:0] reserved;
    byte_cnt_t  byte_cnt;
  } rx_desc_t;

  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    ADDR_ACK,
    DATA,
    BIT9,
    IGNORE
  } frame_state_e;

endpackage

/* hw/rx_desc_builder.sv */
// RX descriptor builder
`timescale 1ns/1ps

module rx_desc_builder (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  i3c_standby_pkg::bus_evt_t   bus_evt_i,
  input  i3c_standby_pkg::frame_evt_t frame_evt_i,
  input  logic                        i3c_mode_i,
  input  logic                        rx_desc_wready_i,
  output logic                        rx_desc_wvalid_o,
  output i3c_standby_pkg::rx_desc_t   rx_desc_wdata_o
);
  import i3c_standby_pkg::*;

  logic      in_frame_q;
  addr7_t    addr_q;
  logic      rnw_q;
  byte_cnt_t cnt_q;
  logic      ovf_q;
  logic      perr_q;
  logic      frame_end;
  logic      desc_load;
  logic      desc_valid_q;
  rx_desc_t  desc_d;
  rx_desc_t  desc_q;

  // Only frames that hit our address produce a descriptor
  assign frame_end = in_frame_q & (bus_evt_i.rstart | bus_evt_i.stop);
  assign desc_load = frame_end & (~desc_valid_q | rx_desc_wready_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_frame_q <= 1'b0;
      cnt_q      <= '0;
      ovf_q      <= 1'b0;
      perr_q     <= 1'b0;
    end else if (frame_evt_i.addr_hit) begin
      in_frame_q <= 1'b1;
      cnt_q      <= '0;
      ovf_q      <= 1'b0;
      perr_q     <= 1'b0;
    end else begin
      if (frame_end) begin
        in_frame_q <= 1'b0;
      end
      if (frame_evt_i.byte_done) begin
        cnt_q <= cnt_q + 16'd1;
      end
      ovf_q  <= ovf_q | frame_evt_i.byte_drop;
      perr_q <= perr_q | frame_evt_i.parity_err;
    end
  end

  always_ff @(posedge clk_i) begin
    if (frame_evt_i.addr_hit) begin
      addr_q <= frame_evt_i.addr;
      rnw_q  <= frame_evt_i.rnw;
    end
    if (desc_load) begin
      desc_q <= desc_d;
    end
  end

  always_comb begin
    desc_d.parity_err = perr_q;
    desc_d.overflow   = ovf_q;
    desc_d.i3c_mode   = i3c_mode_i;
    desc_d.rnw        = rnw_q;
    desc_d.addr       = addr_q;
    desc_d.reserved   = '0;
    desc_d.byte_cnt   = cnt_q;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      desc_valid_q <= 1'b0;
    end else if (desc_load) begin
      desc_valid_q <= 1'b1;
    end else if (rx_desc_wready_i) begin
      desc_valid_q <= 1'b0;
    end
  end

  assign rx_desc_wvalid_o = desc_valid_q;
  assign rx_desc_wdata_o  = desc_q;

  desc_hold_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rx_desc_wvalid_o && !rx_desc_wready_i |=> rx_desc_wvalid_o && $stable(rx_desc_wdata_o));

endmodule

/* i3c_standby.f */
hw/i3c_standby_pkg.sv
hw/bus_cond_detect.sv
hw/frame_receiver.sv
hw/rx_desc_builder.sv
hw/controller_standby.sv
sim/controller_standby_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the standby receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module controller_standby_tb \
  -f i3c_standby.f \
  && ./obj_dir/Vcontroller_standby_tb | tee /dev/stderr \
     | grep -F -q "*** TEST PASSED ***" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* sim/controller_standby_tb.sv */
// Standby receive testbench
`timescale 1ns/1ps

module controller_standby_tb;
  import i3c_standby_pkg::*;

  localparam logic [6:0] own_addr    = 7'h3A;
  localparam logic [6:0] other_addr  = 7'h15;
  localparam int         drain_limit = 4000;

  logic        clk = 1'b0;
  logic        arst_n = 1'b0;
  logic        scl_drv = 1'b1;
  logic        sda_drv = 1'b1;
  logic        sda_line;
  logic        sda_o;
  logic        i3c_mode = 1'b0;
  logic        rx_valid;
  logic        rx_ready = 1'b0;
  data_t       rx_wdata;
  logic        desc_valid;
  logic        desc_ready = 1'b0;
  rx_desc_t    desc_wdata;
  logic [7:0]  bus_addr;
  logic        bus_addr_valid;
  logic        rst_chk = 1'b1;
  logic        manual_ready = 1'b0;
  logic        rx_ready_man = 1'b0;
  logic        desc_ready_man = 1'b0;
  integer      seed = 32'h5d511b21;

  // Scoreboard of expected words
  data_t       exp_data [0:63];
  logic [31:0] exp_desc [0:15];
  logic [5:0]  data_wr = '0;
  logic [5:0]  data_rd = '0;
  logic [3:0]  desc_wr = '0;
  logic [3:0]  desc_rd = '0;
  data_t       exp_data_head;
  logic [31:0] exp_desc_head;

  // Model of the frame in progress
  logic        frame_active = 1'b0;
  logic [6:0]  frame_addr = '0;
  logic [15:0] frame_cnt = '0;
  logic        frame_ovf = 1'b0;
  logic        frame_perr = 1'b0;
  logic [7:0]  exp_bus_addr = '0;
  int          addr_pulses = 0;
  int          exp_addr_pulses = 0;
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          failed_cnt = 0;
  int          test_err_base = 0;

  always #50 clk = ~clk;

  // Open drain bus line
  assign sda_line      = sda_drv & sda_o;
  assign exp_data_head = exp_data[data_rd];
  assign exp_desc_head = exp_desc[desc_rd];

  controller_standby #(
    .SyncStages(2)
  ) dut_i (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .scl_i            (scl_drv),
    .sda_i            (sda_line),
    .sda_o            (sda_o),
    .i3c_mode_i       (i3c_mode),
    .static_addr_i    (own_addr),
    .rx_queue_wvalid_o(rx_valid),
    .rx_queue_wready_i(rx_ready),
    .rx_queue_wdata_o (rx_wdata),
    .rx_desc_wvalid_o (desc_valid),
    .rx_desc_wready_i (desc_ready),
    .rx_desc_wdata_o  (desc_wdata),
    .bus_addr_o       (bus_addr),
    .bus_addr_valid_o (bus_addr_valid)
  );

  always @(posedge clk) begin : ready_gen
    logic [31:0] r;
    r = $random(seed);
    if (manual_ready) begin
      rx_ready   <= rx_ready_man;
      desc_ready <= desc_ready_man;
    end else begin
      rx_ready   <= r[0];
      desc_ready <= r[1];
    end
  end

  // Queue models
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_rd     <= '0;
      desc_rd     <= '0;
      addr_pulses <= 0;
    end else begin
      if (rx_valid && rx_ready) begin
        data_rd <= data_rd + 6'd1;
      end
      if (desc_valid && desc_ready) begin
        desc_rd <= desc_rd + 4'd1;
      end
      if (bus_addr_valid) begin
        addr_pulses <= addr_pulses + 1;
      end
    end
  end

  reset_idle_a : assert property (@(posedge clk)
    rst_chk |-> !rx_valid && !desc_valid && !bus_addr_valid && sda_o)
    else begin
      $display("outputs not idle around reset at %0t", $time);
      err_cnt++;
    end

  addr_a : assert property (@(posedge clk) disable iff (!arst_n)
    bus_addr_valid |-> bus_addr == exp_bus_addr)
    else begin
      $display("[FAIL] %0t bus_addr_o got %h expected %h",
               $time, $sampled(bus_addr), exp_bus_addr);
      err_cnt++;
    end

  rx_extra_a : assert property (@(posedge clk) disable iff (!arst_n)
    rx_valid && rx_ready |-> data_rd != data_wr)
    else begin
      $display("unexpected RX data word written at %0t", $time);
      err_cnt++;
    end

  rx_word_a : assert property (@(posedge clk) disable iff (!arst_n)
    rx_valid && rx_ready && data_rd != data_wr |-> rx_wdata == exp_data_head)
    else begin
      $display("[FAIL] %0t rx_queue_wdata_o got %h expected %h",
               $time, $sampled(rx_wdata), $sampled(exp_data_head));
      err_cnt++;
    end

  rx_hold_a : assert property (@(posedge clk) disable iff (!arst_n)
    rx_valid && !rx_ready |=> rx_valid && $stable(rx_wdata))
    else begin
      $display("RX data word dropped or changed before ready at %0t", $time);
      err_cnt++;
    end

  desc_extra_a : assert property (@(posedge clk) disable iff (!arst_n)
    desc_valid && desc_ready |-> desc_rd != desc_wr)
    else begin
      $display("unexpected RX descriptor written at %0t", $time);
      err_cnt++;
    end

  desc_word_a : assert property (@(posedge clk) disable iff (!arst_n)
    desc_valid && desc_ready && desc_rd != desc_wr |-> desc_wdata == exp_desc_head)
    else begin
      $display("[FAIL] %0t rx_desc_wdata_o got %h expected %h",
               $time, $sampled(desc_wdata), $sampled(exp_desc_head));
      err_cnt++;
    end

  desc_hold_a : assert property (@(posedge clk) disable iff (!arst_n)
    desc_valid && !desc_ready |=> desc_valid && $stable(desc_wdata))
    else begin
      $display("RX descriptor dropped or changed before ready at %0t", $time);
      err_cnt++;
    end

  // One bus bit, 8 clocks, SCL high from clock 2 to 5
  task automatic clock_bit(input logic b, output logic seen);
    @(posedge clk);
    sda_drv <= b;
    repeat (2) @(posedge clk);
    scl_drv <= 1'b1;
    repeat (2) @(posedge clk);
    seen = sda_line;
    @(posedge clk);
    scl_drv <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  // Also used as repeated START from a low SCL
  task automatic bus_start();
    @(posedge clk);
    sda_drv <= 1'b1;
    repeat (2) @(posedge clk);
    scl_drv <= 1'b1;
    repeat (3) @(posedge clk);
    sda_drv <= 1'b0;
    repeat (3) @(posedge clk);
    scl_drv <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic bus_stop();
    @(posedge clk);
    sda_drv <= 1'b0;
    repeat (2) @(posedge clk);
    scl_drv <= 1'b1;
    repeat (3) @(posedge clk);
    sda_drv <= 1'b1;
    repeat (6) @(posedge clk);
  endtask

  task automatic send_byte(input data_t b, input logic ninth, input logic exp_ninth,
                           input string slot);
    data_t sh;
    logic  seen;
    sh = b;
    repeat (8) begin
      clock_bit(sh[7], seen);
      sh = {sh[6:0], 1'b0};
    end
    clock_bit(ninth, seen);
    assert (seen == exp_ninth) else begin
      $display("[FAIL] %0t sda_line in %s slot got %b expected %b",
               $time, slot, seen, exp_ninth);
      err_cnt++;
    end
  endtask

  task automatic send_addr(input logic [6:0] a, input logic rnw);
    frame_active = (a == own_addr) && !rnw;
    frame_addr   = a;
    frame_cnt    = '0;
    frame_ovf    = 1'b0;
    frame_perr   = 1'b0;
    exp_bus_addr = {a, rnw};
    exp_addr_pulses++;
    send_byte({a, rnw}, 1'b1, !frame_active, "address ACK");
    assert (addr_pulses == exp_addr_pulses) else begin
      $display("bus_addr_valid_o did not pulse once for address %h at %0t", {a, rnw}, $time);
      err_cnt++;
    end
  endtask

  task automatic send_data(input data_t d, input logic bad_tbit, input logic dropped);
    logic ninth;
    logic exp_ninth;
    if (i3c_mode) begin
      // Correct T-bit gives odd parity over nine bits
      ninth     = ~(^d) ^ bad_tbit;
      exp_ninth = ninth;
    end else begin
      ninth     = 1'b1;
      exp_ninth = !frame_active;
    end
    if (frame_active) begin
      if (dropped) begin
        frame_ovf = 1'b1;
      end else begin
        exp_data[data_wr] = d;
        data_wr           = data_wr + 6'd1;
        frame_cnt         = frame_cnt + 16'd1;
      end
      if (i3c_mode && bad_tbit) begin
        frame_perr = 1'b1;
      end
    end
    send_byte(d, ninth, exp_ninth, "data ACK");
  endtask

  task automatic end_frame(input logic restart);
    if (frame_active) begin
      exp_desc[desc_wr] = {frame_perr, frame_ovf, i3c_mode, 1'b0, frame_addr, 5'd0, frame_cnt};
      desc_wr           = desc_wr + 4'd1;
    end
    frame_active = 1'b0;
    if (restart) begin
      bus_start();
    end else begin
      bus_stop();
    end
  endtask

  task automatic drain(input string what);
    int n;
    n = 0;
    while ((data_rd != data_wr || desc_rd != desc_wr) && n < drain_limit) begin
      @(posedge clk);
      n++;
    end
    if (data_rd != data_wr || desc_rd != desc_wr) begin
      $display("timeout while waiting for the %s words to arrive", what);
      err_cnt++;
    end
  endtask

  task automatic wait_desc_valid();
    int n;
    n = 0;
    while (!desc_valid && n < drain_limit) begin
      @(posedge clk);
      n++;
    end
    if (!desc_valid) begin
      $display("timeout while waiting for rx_desc_wvalid_o");
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      failed_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  initial begin
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    repeat (3) @(posedge clk);
    rst_chk <= 1'b0;
    finish_test("reset");

    bus_start();
    send_addr(own_addr, 1'b0);
    send_data(8'hA5, 1'b0, 1'b0);
    send_data(8'h3C, 1'b0, 1'b0);
    send_data(8'hFF, 1'b0, 1'b0);
    send_data(8'h00, 1'b0, 1'b0);
    end_frame(1'b0);
    drain("I2C write");
    finish_test("I2C own-address write");

    bus_start();
    send_addr(other_addr, 1'b0);
    send_data(8'h5A, 1'b0, 1'b0);
    end_frame(1'b0);
    bus_start();
    send_addr(own_addr, 1'b1);
    end_frame(1'b0);
    drain("ignored frames");
    finish_test("foreign address and read");

    i3c_mode <= 1'b1;
    @(posedge clk);
    bus_start();
    send_addr(own_addr, 1'b0);
    send_data(8'h81, 1'b0, 1'b0);
    send_data(8'h7E, 1'b1, 1'b0);
    send_data(8'hC3, 1'b0, 1'b0);
    end_frame(1'b0);
    bus_start();
    send_addr(own_addr, 1'b0);
    send_data(8'h10, 1'b0, 1'b0);
    send_data(8'h3F, 1'b0, 1'b0);
    end_frame(1'b0);
    drain("I3C write");
    i3c_mode <= 1'b0;
    @(posedge clk);
    finish_test("I3C T-bit");

    // Both queues stall, second byte finds the first still waiting
    manual_ready <= 1'b1;
    @(posedge clk);
    bus_start();
    send_addr(own_addr, 1'b0);
    send_data(8'h96, 1'b0, 1'b0);
    send_data(8'h69, 1'b0, 1'b1);
    rx_ready_man <= 1'b1;
    end_frame(1'b0);
    wait_desc_valid();
    repeat (16) @(posedge clk);
    desc_ready_man <= 1'b1;
    drain("back-pressure");
    manual_ready   <= 1'b0;
    rx_ready_man   <= 1'b0;
    desc_ready_man <= 1'b0;
    finish_test("back-pressure");

    bus_start();
    send_addr(own_addr, 1'b0);
    send_data(8'h11, 1'b0, 1'b0);
    send_data(8'h22, 1'b0, 1'b0);
    end_frame(1'b1);
    // First descriptor must arrive while the bus still waits after Sr
    drain("first frame before repeated START address");
    send_addr(own_addr, 1'b0);
    send_data(8'h33, 1'b0, 1'b0);
    end_frame(1'b0);
    drain("second frame");
    finish_test("repeated START");

    $display("tests %0d, failed %0d, errors %0d", test_cnt, failed_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
